// File: verilog/id2_macros.svh
`ifndef ID2_MACROS_SVH
`define ID2_MACROS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define REG_COUNT   32
`define IMM_W       16

// opcode field codes
`define OP_SPECIAL  6'h00
`define OP_ADDI     6'h08
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f

// function field codes under special
`define FUNC_SLL      6'h00
`define FUNC_SRL      6'h02
`define FUNC_SRA      6'h03
`define FUNC_SLLV     6'h04
`define FUNC_SRLV     6'h06
`define FUNC_SRAV     6'h07
`define FUNC_SYSCALL  6'h0c
`define FUNC_BREAK    6'h0d
`define FUNC_ADD      6'h20
`define FUNC_ADDU     6'h21
`define FUNC_SUB      6'h22
`define FUNC_SUBU     6'h23
`define FUNC_AND      6'h24
`define FUNC_OR       6'h25
`define FUNC_XOR      6'h26
`define FUNC_NOR      6'h27
`define FUNC_SLT      6'h2a
`define FUNC_SLTU     6'h2b

`endif

// File: verilog/id2_pkg.sv
`include "id2_macros.svh"

package id2_pkg;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             sa;
        logic [5:0]             func;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`IMM_W-1:0]      imm;
    } i_fields_t;

    // same 32-bit word, R-type or I-type view
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_word_t;

    // op_special must stay the top bit
    typedef struct packed {
        logic op_special;
        logic op_addi;
        logic op_addiu;
        logic op_slti;
        logic op_sltiu;
        logic op_andi;
        logic op_ori;
        logic op_xori;
        logic op_lui;
    } op_onehot_t;

    typedef struct packed {
        logic fn_add;
        logic fn_addu;
        logic fn_sub;
        logic fn_subu;
        logic fn_slt;
        logic fn_sltu;
        logic fn_and;
        logic fn_nor;
        logic fn_or;
        logic fn_xor;
        logic fn_sll;
        logic fn_sllv;
        logic fn_sra;
        logic fn_srav;
        logic fn_srl;
        logic fn_srlv;
        logic fn_syscall;
        logic fn_break;
    } func_onehot_t;

    // code 7 left unused, selects nothing
    typedef enum logic [2:0] {
        FWD_NOP      = 3'd0,
        FWD_EXC_ALU  = 3'd1,
        FWD_EXP_ALU  = 3'd2,
        FWD_MEMC_ALU = 3'd3,
        FWD_MEMC_MEM = 3'd4,
        FWD_MEMP_ALU = 3'd5,
        FWD_MEMP_MEM = 3'd6
    } fwd_sel_t;

    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_AND  = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_OR   = 4'd7,
        ALU_XOR  = 4'd8,
        ALU_SLL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_SRL  = 4'd11,
        ALU_LUI  = 4'd12
    } alu_sel_t;

    typedef enum logic {
        SRC_A_RS = 1'b0,
        SRC_A_RT = 1'b1
    } src_a_sel_t;

    typedef enum logic [2:0] {
        SRC_B_NOP  = 3'd0,
        SRC_B_RT   = 3'd1,
        SRC_B_IMME = 3'd2,
        SRC_B_RS   = 3'd3,
        SRC_B_SA   = 3'd4
    } src_b_sel_t;

endpackage

// File: verilog/inst_classifier.sv
`timescale 1ns/1ns

`include "id2_macros.svh"

module inst_classifier (
    input  id2_pkg::inst_word_t   instr,
    output id2_pkg::op_onehot_t   op_onehot,
    output id2_pkg::func_onehot_t func_onehot,
    output logic                  is_kept
);

    logic [5:0] opcode;
    logic [5:0] func;
    logic       special;
    logic       sa_zero;

    assign opcode  = instr.r.opcode;
    assign func    = instr.r.func;
    assign special = (opcode == `OP_SPECIAL);
    // only constant shifts and syscall/break may use the sa bits
    assign sa_zero = (instr.r.sa == 5'd0);

    assign op_onehot.op_special = special;
    assign op_onehot.op_addi    = (opcode == `OP_ADDI);
    assign op_onehot.op_addiu   = (opcode == `OP_ADDIU);
    assign op_onehot.op_slti    = (opcode == `OP_SLTI);
    assign op_onehot.op_sltiu   = (opcode == `OP_SLTIU);
    assign op_onehot.op_andi    = (opcode == `OP_ANDI);
    assign op_onehot.op_ori     = (opcode == `OP_ORI);
    assign op_onehot.op_xori    = (opcode == `OP_XORI);
    assign op_onehot.op_lui     = (opcode == `OP_LUI);

    assign func_onehot.fn_add     = special & sa_zero & (func == `FUNC_ADD);
    assign func_onehot.fn_addu    = special & sa_zero & (func == `FUNC_ADDU);
    assign func_onehot.fn_sub     = special & sa_zero & (func == `FUNC_SUB);
    assign func_onehot.fn_subu    = special & sa_zero & (func == `FUNC_SUBU);
    assign func_onehot.fn_slt     = special & sa_zero & (func == `FUNC_SLT);
    assign func_onehot.fn_sltu    = special & sa_zero & (func == `FUNC_SLTU);
    assign func_onehot.fn_and     = special & sa_zero & (func == `FUNC_AND);
    assign func_onehot.fn_nor     = special & sa_zero & (func == `FUNC_NOR);
    assign func_onehot.fn_or      = special & sa_zero & (func == `FUNC_OR);
    assign func_onehot.fn_xor     = special & sa_zero & (func == `FUNC_XOR);
    assign func_onehot.fn_sll     = special & (func == `FUNC_SLL);
    assign func_onehot.fn_sllv    = special & sa_zero & (func == `FUNC_SLLV);
    assign func_onehot.fn_sra     = special & (func == `FUNC_SRA);
    assign func_onehot.fn_srav    = special & sa_zero & (func == `FUNC_SRAV);
    assign func_onehot.fn_srl     = special & (func == `FUNC_SRL);
    assign func_onehot.fn_srlv    = special & sa_zero & (func == `FUNC_SRLV);
    assign func_onehot.fn_syscall = special & (func == `FUNC_SYSCALL);
    assign func_onehot.fn_break   = special & (func == `FUNC_BREAK);

    // special alone is not an instruction, so leave bit 8 out
    assign is_kept = $onehot({op_onehot[7:0], func_onehot});

endmodule

// File: verilog/ctrl_decoder.sv
`timescale 1ns/1ns

module ctrl_decoder (
    input  id2_pkg::op_onehot_t   op_onehot,
    input  id2_pkg::func_onehot_t func_onehot,
    input  logic                  is_kept,
    input  logic                  valid,
    output id2_pkg::alu_sel_t     alu_sel,
    output id2_pkg::src_a_sel_t   src_a_sel,
    output id2_pkg::src_b_sel_t   src_b_sel,
    output logic                  sign_ext,
    output logic                  is_check_ov,
    output logic                  is_syscall,
    output logic                  is_break,
    output logic                  is_ri
);

    import id2_pkg::*;

    logic r_arith;
    logic i_type;
    logic var_shift;
    logic const_shift;

    // instruction groups
    assign r_arith = func_onehot.fn_add | func_onehot.fn_addu |
                     func_onehot.fn_sub | func_onehot.fn_subu |
                     func_onehot.fn_slt | func_onehot.fn_sltu |
                     func_onehot.fn_and | func_onehot.fn_nor  |
                     func_onehot.fn_or  | func_onehot.fn_xor;

    assign i_type = op_onehot.op_addi | op_onehot.op_addiu |
                    op_onehot.op_slti | op_onehot.op_sltiu |
                    op_onehot.op_andi | op_onehot.op_ori   |
                    op_onehot.op_xori | op_onehot.op_lui;

    assign var_shift   = func_onehot.fn_sllv | func_onehot.fn_srav | func_onehot.fn_srlv;
    assign const_shift = func_onehot.fn_sll | func_onehot.fn_sra | func_onehot.fn_srl;

    // and-or over one-hot groups, at most one term is live
    assign alu_sel = alu_sel_t'(
        ({4{func_onehot.fn_add | func_onehot.fn_addu |
            op_onehot.op_addi | op_onehot.op_addiu}} & ALU_ADD)      |
        ({4{func_onehot.fn_sub | func_onehot.fn_subu}} & ALU_SUB)    |
        ({4{func_onehot.fn_slt | op_onehot.op_slti}} & ALU_SLT)      |
        ({4{func_onehot.fn_sltu | op_onehot.op_sltiu}} & ALU_SLTU)   |
        ({4{func_onehot.fn_and | op_onehot.op_andi}} & ALU_AND)      |
        ({4{func_onehot.fn_nor}} & ALU_NOR)                          |
        ({4{func_onehot.fn_or | op_onehot.op_ori}} & ALU_OR)         |
        ({4{func_onehot.fn_xor | op_onehot.op_xori}} & ALU_XOR)      |
        ({4{func_onehot.fn_sll | func_onehot.fn_sllv}} & ALU_SLL)    |
        ({4{func_onehot.fn_sra | func_onehot.fn_srav}} & ALU_SRA)    |
        ({4{func_onehot.fn_srl | func_onehot.fn_srlv}} & ALU_SRL)    |
        ({4{op_onehot.op_lui}} & ALU_LUI));

    // shifts take the shifted value from rt
    assign src_a_sel = (var_shift | const_shift) ? SRC_A_RT : SRC_A_RS;

    always_comb begin
        if (r_arith) begin
            src_b_sel = SRC_B_RT;
        end else if (i_type) begin
            src_b_sel = SRC_B_IMME;
        end else if (var_shift) begin
            src_b_sel = SRC_B_RS;
        end else if (const_shift) begin
            src_b_sel = SRC_B_SA;
        end else begin
            src_b_sel = SRC_B_NOP;
        end
    end

    assign sign_ext = op_onehot.op_addi | op_onehot.op_addiu |
                      op_onehot.op_slti | op_onehot.op_sltiu;

    assign is_check_ov = func_onehot.fn_add | func_onehot.fn_sub | op_onehot.op_addi;

    assign is_syscall = func_onehot.fn_syscall;
    assign is_break   = func_onehot.fn_break;
    assign is_ri      = valid & ~is_kept;

endmodule

// File: verilog/operand_mux.sv
`timescale 1ns/1ns

`include "id2_macros.svh"

module operand_mux (
    input  id2_pkg::inst_word_t  instr,
    input  logic                 sign_ext,
    input  id2_pkg::fwd_sel_t    forward_rs,
    input  id2_pkg::fwd_sel_t    forward_rt,
    input  logic [`WORD_W-1:0]   reg_rs_data,
    input  logic [`WORD_W-1:0]   reg_rt_data,
    input  logic [`WORD_W-1:0]   exc_alu_res,
    input  logic [`WORD_W-1:0]   exp_alu_res,
    input  logic [`WORD_W-1:0]   memc_alu_res,
    input  logic [`WORD_W-1:0]   memc_r_data,
    input  logic [`WORD_W-1:0]   memp_alu_res,
    input  logic [`WORD_W-1:0]   memp_r_data,
    output logic [`WORD_W-1:0]   rs_data,
    output logic [`WORD_W-1:0]   rt_data,
    output logic [`WORD_W-1:0]   ext_imme,
    output logic [4:0]           sa
);

    import id2_pkg::*;

    // unused code 7 matches no term and gives zero
    function automatic logic [`WORD_W-1:0] fwd_pick(
        input fwd_sel_t           sel,
        input logic [`WORD_W-1:0] reg_data,
        input logic [`WORD_W-1:0] exc_alu,
        input logic [`WORD_W-1:0] exp_alu,
        input logic [`WORD_W-1:0] memc_alu,
        input logic [`WORD_W-1:0] memc_mem,
        input logic [`WORD_W-1:0] memp_alu,
        input logic [`WORD_W-1:0] memp_mem
    );
        return ({`WORD_W{sel == FWD_NOP}}      & reg_data) |
               ({`WORD_W{sel == FWD_EXC_ALU}}  & exc_alu)  |
               ({`WORD_W{sel == FWD_EXP_ALU}}  & exp_alu)  |
               ({`WORD_W{sel == FWD_MEMC_ALU}} & memc_alu) |
               ({`WORD_W{sel == FWD_MEMC_MEM}} & memc_mem) |
               ({`WORD_W{sel == FWD_MEMP_ALU}} & memp_alu) |
               ({`WORD_W{sel == FWD_MEMP_MEM}} & memp_mem);
    endfunction

    assign rs_data = fwd_pick(forward_rs, reg_rs_data, exc_alu_res, exp_alu_res,
                              memc_alu_res, memc_r_data, memp_alu_res, memp_r_data);
    assign rt_data = fwd_pick(forward_rt, reg_rt_data, exc_alu_res, exp_alu_res,
                              memc_alu_res, memc_r_data, memp_alu_res, memp_r_data);

    assign ext_imme = sign_ext ?
        {{(`WORD_W-`IMM_W){instr.i.imm[`IMM_W-1]}}, instr.i.imm} :
        {{(`WORD_W-`IMM_W){1'b0}}, instr.i.imm};

    assign sa = instr.r.sa;

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns

`include "id2_macros.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] r_addr_1,
    input  logic [`REG_ADDR_W-1:0] r_addr_2,
    output logic [`WORD_W-1:0]     r_data_1,
    output logic [`WORD_W-1:0]     r_data_2,
    input  logic                   w_ena,
    input  logic [`REG_ADDR_W-1:0] w_addr,
    input  logic [`WORD_W-1:0]     w_data
);

    logic [`WORD_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (w_ena && (w_addr != '0)) begin
            regs[w_addr] <= w_data;
        end
    end

    // no write-through, forwarding covers same-cycle hazards
    assign r_data_1 = (r_addr_1 == '0) ? '0 : regs[r_addr_1];
    assign r_data_2 = (r_addr_2 == '0) ? '0 : regs[r_addr_2];

endmodule

// File: verilog/id2_stage.sv
`timescale 1ns/1ns

`include "id2_macros.svh"

module id2_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  id2_pkg::inst_word_t    instr,
    input  logic                   valid,
    input  id2_pkg::fwd_sel_t      forward_rs,
    input  id2_pkg::fwd_sel_t      forward_rt,
    input  logic [`WORD_W-1:0]     exc_alu_res,
    input  logic [`WORD_W-1:0]     exp_alu_res,
    input  logic [`WORD_W-1:0]     memc_alu_res,
    input  logic [`WORD_W-1:0]     memc_r_data,
    input  logic [`WORD_W-1:0]     memp_alu_res,
    input  logic [`WORD_W-1:0]     memp_r_data,
    input  logic                   w_reg_ena,
    input  logic [`REG_ADDR_W-1:0] w_reg_addr,
    input  logic [`WORD_W-1:0]     w_reg_data,
    output logic [`WORD_W-1:0]     rs_data,
    output logic [`WORD_W-1:0]     rt_data,
    output logic [`WORD_W-1:0]     ext_imme,
    output logic [4:0]             sa,
    output id2_pkg::alu_sel_t      alu_sel,
    output id2_pkg::src_a_sel_t    src_a_sel,
    output id2_pkg::src_b_sel_t    src_b_sel,
    output logic                   is_check_ov,
    output logic                   is_syscall,
    output logic                   is_break,
    output logic                   is_ri
);

    import id2_pkg::*;

    op_onehot_t         op_onehot;
    func_onehot_t       func_onehot;
    logic               is_kept;
    logic               sign_ext;
    logic [`WORD_W-1:0] reg_rs_data;
    logic [`WORD_W-1:0] reg_rt_data;

    inst_classifier u_classifier (
        .instr       (instr),
        .op_onehot   (op_onehot),
        .func_onehot (func_onehot),
        .is_kept     (is_kept)
    );

    ctrl_decoder u_decoder (
        .op_onehot   (op_onehot),
        .func_onehot (func_onehot),
        .is_kept     (is_kept),
        .valid       (valid),
        .alu_sel     (alu_sel),
        .src_a_sel   (src_a_sel),
        .src_b_sel   (src_b_sel),
        .sign_ext    (sign_ext),
        .is_check_ov (is_check_ov),
        .is_syscall  (is_syscall),
        .is_break    (is_break),
        .is_ri       (is_ri)
    );

    operand_mux u_operand_mux (
        .instr        (instr),
        .sign_ext     (sign_ext),
        .forward_rs   (forward_rs),
        .forward_rt   (forward_rt),
        .reg_rs_data  (reg_rs_data),
        .reg_rt_data  (reg_rt_data),
        .exc_alu_res  (exc_alu_res),
        .exp_alu_res  (exp_alu_res),
        .memc_alu_res (memc_alu_res),
        .memc_r_data  (memc_r_data),
        .memp_alu_res (memp_alu_res),
        .memp_r_data  (memp_r_data),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .ext_imme     (ext_imme),
        .sa           (sa)
    );

    // read ports addressed straight from rs/rt fields
    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .r_addr_1 (instr.r.rs),
        .r_addr_2 (instr.r.rt),
        .r_data_1 (reg_rs_data),
        .r_data_2 (reg_rt_data),
        .w_ena    (w_reg_ena),
        .w_addr   (w_reg_addr),
        .w_data   (w_reg_data)
    );

endmodule

// File: testbench/id2_stage_asserts.sv
`timescale 1ns/1ns

`include "id2_macros.svh"

module id2_stage_asserts (
    input logic               clk,
    input logic               reset,
    input logic               valid,
    input logic               is_ri,
    input logic               is_syscall,
    input logic               is_break,
    input logic [`WORD_W-1:0] ext_imme
);

    int error_count = 0;

    // reserved only flagged on a valid word
    ri_needs_valid: assert property (@(posedge clk) disable iff (reset) is_ri |-> valid)
        else begin
            error_count++;
            $error("is_ri high while valid is low");
        end

    sys_brk_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(is_syscall && is_break))
        else begin
            error_count++;
            $error("is_syscall and is_break high together");
        end

    // upper half copies the sign bit or stays zero
    ext_upper_uniform: assert property (@(posedge clk) disable iff (reset)
        (ext_imme[`WORD_W-1:`IMM_W] == '0) || (ext_imme[`WORD_W-1:`IMM_W] == '1))
        else begin
            error_count++;
            $error("ext_imme upper half is mixed");
        end

endmodule

// File: testbench/id2_stage_tb.sv
`timescale 1ns/1ns

`include "id2_macros.svh"

module id2_stage_tb;

    import id2_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_TESTS  = 64;

    typedef struct packed {
        logic [63:0]  kind;
        inst_word_t   instr;
        logic         valid;
        fwd_sel_t     fwd_rs;
        fwd_sel_t     fwd_rt;
        logic [31:0]  seed;
        alu_sel_t     alu;
        src_a_sel_t   src_a;
        src_b_sel_t   src_b;
        logic         ov;
        logic         sys;
        logic         brk;
        logic         ri;
    } test_vec_t;

    logic                   clk;
    logic                   reset;
    inst_word_t             instr;
    logic                   valid;
    fwd_sel_t               forward_rs;
    fwd_sel_t               forward_rt;
    logic [`WORD_W-1:0]     exc_alu_res;
    logic [`WORD_W-1:0]     exp_alu_res;
    logic [`WORD_W-1:0]     memc_alu_res;
    logic [`WORD_W-1:0]     memc_r_data;
    logic [`WORD_W-1:0]     memp_alu_res;
    logic [`WORD_W-1:0]     memp_r_data;
    logic                   w_reg_ena;
    logic [`REG_ADDR_W-1:0] w_reg_addr;
    logic [`WORD_W-1:0]     w_reg_data;
    logic [`WORD_W-1:0]     rs_data;
    logic [`WORD_W-1:0]     rt_data;
    logic [`WORD_W-1:0]     ext_imme;
    logic [4:0]             sa;
    alu_sel_t               alu_sel;
    src_a_sel_t             src_a_sel;
    src_b_sel_t             src_b_sel;
    logic                   is_check_ov;
    logic                   is_syscall;
    logic                   is_break;
    logic                   is_ri;

    test_vec_t          tests [MAX_TESTS];
    int                 num_tests;
    int                 cycles;
    int                 cycle_limit;
    logic [`WORD_W-1:0] shadow [`REG_COUNT];

    id2_stage DUT (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .valid        (valid),
        .forward_rs   (forward_rs),
        .forward_rt   (forward_rt),
        .exc_alu_res  (exc_alu_res),
        .exp_alu_res  (exp_alu_res),
        .memc_alu_res (memc_alu_res),
        .memc_r_data  (memc_r_data),
        .memp_alu_res (memp_alu_res),
        .memp_r_data  (memp_r_data),
        .w_reg_ena    (w_reg_ena),
        .w_reg_addr   (w_reg_addr),
        .w_reg_data   (w_reg_data),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .ext_imme     (ext_imme),
        .sa           (sa),
        .alu_sel      (alu_sel),
        .src_a_sel    (src_a_sel),
        .src_b_sel    (src_b_sel),
        .is_check_ov  (is_check_ov),
        .is_syscall   (is_syscall),
        .is_break     (is_break),
        .is_ri        (is_ri)
    );

    bind id2_stage id2_stage_asserts u_asserts (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .is_ri      (is_ri),
        .is_syscall (is_syscall),
        .is_break   (is_break),
        .ext_imme   (ext_imme)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    // bound assertions sample on the rising edge
    always @(negedge clk) begin
        if (DUT.u_asserts.error_count != 0) begin
            fail_now("a bound assertion failed");
        end
    end

    task automatic fail_now(input string what);
        $display("ERROR: %s", what);
        $display("TB FAILED");
        $fatal(1, "stopping");
    endtask

    task automatic check_word(input string name, input logic [`WORD_W-1:0] got,
                              input logic [`WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_alu(input alu_sel_t got, input alu_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: alu_sel got %0d expected %0d", $time, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_src_a(input src_a_sel_t got, input src_a_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: src_a_sel got %0d expected %0d", $time, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_src_b(input src_b_sel_t got, input src_b_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: src_b_sel got %0d expected %0d", $time, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // reference forwarding, code 7 selects nothing
    function automatic logic [`WORD_W-1:0] expected_operand(input fwd_sel_t code,
                                                            input logic [`WORD_W-1:0] reg_val);
        case (code)
            FWD_NOP:      return reg_val;
            FWD_EXC_ALU:  return exc_alu_res;
            FWD_EXP_ALU:  return exp_alu_res;
            FWD_MEMC_ALU: return memc_alu_res;
            FWD_MEMC_MEM: return memc_r_data;
            FWD_MEMP_ALU: return memp_alu_res;
            FWD_MEMP_MEM: return memp_r_data;
            default:      return '0;
        endcase
    endfunction

    function automatic logic [`WORD_W-1:0] expected_imme(input logic [31:0] word);
        logic [5:0]  op;
        logic [15:0] imm;
        op  = word[31:26];
        imm = word[15:0];
        if (op == `OP_ADDI || op == `OP_ADDIU || op == `OP_SLTI || op == `OP_SLTIU) begin
            return {{16{imm[15]}}, imm};
        end
        return {16'd0, imm};
    endfunction

    task automatic load_tests();
        int              fd;
        int              n;
        logic [8*160-1:0] line;
        logic [63:0]     kind;
        logic [31:0]     iw;
        logic [31:0]     seed;
        int              v, frs, frt, alu, a_sel, b_sel, ov, sys, brk, ri;
        fd = $fopen("testbench/id2_tests.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open testbench/id2_tests.txt");
        end
        num_tests = 0;
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %h %d %d %d %h %d %d %d %d %d %d %d", kind, iw, v,
                        frs, frt, seed, alu, a_sel, b_sel, ov, sys, brk, ri);
            // comment and blank lines do not parse fully
            if (n == 13) begin
                if (num_tests >= MAX_TESTS) begin
                    fail_now("too many test lines in the vector file");
                end
                tests[num_tests] = {kind, iw, v[0], frs[2:0], frt[2:0], seed, alu[3:0],
                                    a_sel[0], b_sel[2:0], ov[0], sys[0], brk[0], ri[0]};
                num_tests++;
            end
        end
        $fclose(fd);
        if (num_tests == 0) begin
            fail_now("no test lines found in the vector file");
        end
    endtask

    task automatic run_test(input test_vec_t t);
        logic               is_write;
        logic [`WORD_W-1:0] wdata;
        logic [`WORD_W-1:0] exp_rs;
        logic [`WORD_W-1:0] exp_rt;
        @(negedge clk);
        is_write     = (t.kind == "write");
        wdata        = $urandom ^ t.seed;
        instr        = t.instr;
        valid        = t.valid;
        forward_rs   = t.fwd_rs;
        forward_rt   = t.fwd_rt;
        exc_alu_res  = $urandom ^ t.seed;
        exp_alu_res  = $urandom ^ t.seed;
        memc_alu_res = $urandom ^ t.seed;
        memc_r_data  = $urandom ^ t.seed;
        memp_alu_res = $urandom ^ t.seed;
        memp_r_data  = $urandom ^ t.seed;
        w_reg_ena    = is_write;
        w_reg_addr   = t.instr.r.rd;
        w_reg_data   = wdata;
        #(CLK_PERIOD / 4);
        exp_rs = expected_operand(t.fwd_rs, shadow[t.instr.r.rs]);
        exp_rt = expected_operand(t.fwd_rt, shadow[t.instr.r.rt]);
        check_word("rs_data", rs_data, exp_rs);
        check_word("rt_data", rt_data, exp_rt);
        check_word("ext_imme", ext_imme, expected_imme(t.instr));
        check_word("sa", {27'd0, sa}, {27'd0, t.instr.r.sa});
        if (t.kind == "decode") begin
            check_alu(alu_sel, t.alu);
            check_src_a(src_a_sel, t.src_a);
            check_src_b(src_b_sel, t.src_b);
            check_flag("is_check_ov", is_check_ov, t.ov);
            check_flag("is_syscall", is_syscall, t.sys);
            check_flag("is_break", is_break, t.brk);
            check_flag("is_ri", is_ri, t.ri);
        end
        // lands on the coming rising edge
        if (is_write && t.instr.r.rd != 0) begin
            shadow[t.instr.r.rd] = wdata;
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        instr        = '0;
        valid        = 1'b0;
        forward_rs   = FWD_NOP;
        forward_rt   = FWD_NOP;
        exc_alu_res  = '0;
        exp_alu_res  = '0;
        memc_alu_res = '0;
        memc_r_data  = '0;
        memp_alu_res = '0;
        memp_r_data  = '0;
        w_reg_ena    = 1'b0;
        w_reg_addr   = '0;
        w_reg_data   = '0;
        cycles       = 0;
        cycle_limit  = 0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            shadow[r] = '0;
        end
        void'($urandom(32'h1e81));
        load_tests();
        cycle_limit = 4 * num_tests + 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            run_test(tests[i]);
        end
        @(negedge clk);
        w_reg_ena = 1'b0;
        valid     = 1'b0;
        @(negedge clk);
        if (DUT.u_asserts.error_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d assertion failures", DUT.u_asserts.error_count);
            $display("TB FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: testbench/id2_tests.txt
# kind instr valid fwd_rs fwd_rt seed alu_sel src_a src_b check_ov syscall break ri
# write targets the rd field; control columns are checked on decode lines only
read   00220000 1 0 0 00000000  0 0 0 0 0 0 0
read   03f10000 1 0 0 00000000  0 0 0 0 0 0 0
write  00a52820 1 0 0 00001111  0 0 0 0 0 0 0
read   00a00000 1 0 0 00000000  0 0 0 0 0 0 0
write  00000000 1 0 0 0000dead  0 0 0 0 0 0 0
read   00050000 1 0 0 00000000  0 0 0 0 0 0 0
write  01294821 1 0 0 5a5a0000  0 0 0 0 0 0 0
read   01250000 1 0 0 00000000  0 0 0 0 0 0 0
read   01250000 1 1 2 00000a0a  0 0 0 0 0 0 0
read   01250000 1 3 4 0000b0b0  0 0 0 0 0 0 0
read   01250000 1 5 6 00c0c000  0 0 0 0 0 0 0
read   01250000 1 7 7 ffffffff  0 0 0 0 0 0 0
decode 00221820 1 0 0 00000000  1 0 1 1 0 0 0
decode 00221821 1 0 0 00000000  1 0 1 0 0 0 0
decode 00221822 1 0 0 00000000  2 0 1 1 0 0 0
decode 00221823 1 0 0 00000000  2 0 1 0 0 0 0
decode 0022182a 1 0 0 00000000  3 0 1 0 0 0 0
decode 0022182b 1 0 0 00000000  4 0 1 0 0 0 0
decode 00221824 1 0 0 00000000  5 0 1 0 0 0 0
decode 00221827 1 0 0 00000000  6 0 1 0 0 0 0
decode 00221825 1 0 0 00000000  7 0 1 0 0 0 0
decode 00221826 1 0 0 00000000  8 0 1 0 0 0 0
decode 00021900 1 0 0 00000000  9 1 4 0 0 0 0
decode 00221804 1 0 0 00000000  9 1 3 0 0 0 0
decode 00021fc3 1 0 0 00000000 10 1 4 0 0 0 0
decode 00221807 1 0 0 00000000 10 1 3 0 0 0 0
decode 00021842 1 0 0 00000000 11 1 4 0 0 0 0
decode 00221806 1 0 0 00000000 11 1 3 0 0 0 0
decode 0000000c 1 0 0 00000000  0 0 0 0 1 0 0
decode 0000000d 1 0 0 00000000  0 0 0 0 0 1 0
decode 2022fffc 1 0 0 00000000  1 0 2 1 0 0 0
decode 24228000 1 0 0 00000000  1 0 2 0 0 0 0
decode 28227fff 1 0 0 00000000  3 0 2 0 0 0 0
decode 2c229abc 1 0 0 00000000  4 0 2 0 0 0 0
decode 3022f0f0 1 0 0 00000000  5 0 2 0 0 0 0
decode 34228001 1 0 0 00000000  7 0 2 0 0 0 0
decode 3822ffff 1 0 0 00000000  8 0 2 0 0 0 0
decode 3c028765 1 0 0 00000000 12 0 2 0 0 0 0
decode 8c220004 1 0 0 00000000  0 0 0 0 0 0 1
decode 8c220004 0 0 0 00000000  0 0 0 0 0 0 0
decode 00220018 1 0 0 00000000  0 0 0 0 0 0 1
decode 00220018 0 0 0 00000000  0 0 0 0 0 0 0
decode 10220008 1 0 0 00000000  0 0 0 0 0 0 1
decode 0000000c 0 0 0 00000000  0 0 0 0 1 0 0
decode 00000000 1 0 0 00000000  9 1 4 0 0 0 0

// File: id2_stage.f
+incdir+verilog
verilog/id2_pkg.sv
verilog/inst_classifier.sv
verilog/ctrl_decoder.sv
verilog/operand_mux.sv
verilog/reg_file.sv
verilog/id2_stage.sv
testbench/id2_stage_asserts.sv
testbench/id2_stage_tb.sv

// File: Bender.yml
package:
  name: id2_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/id2_pkg.sv
      - verilog/inst_classifier.sv
      - verilog/ctrl_decoder.sv
      - verilog/operand_mux.sv
      - verilog/reg_file.sv
      - verilog/id2_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/id2_stage_asserts.sv
      - testbench/id2_stage_tb.sv
